// File: common/cpu_defs_pkg.sv
package cpu_defs_pkg;

    // byte address and word address widths
    localparam int PC_W     = 32;
    localparam int WPC_W    = 30;            // pc[31:2], used for tags and stored targets
    localparam int WORD_LSB = PC_W - WPC_W;  // byte offset bits dropped from a word addr

    // register operand width for branch compares
    localparam int DATA_W = 32;

    // direct-mapped table, index is pc[9:2]
    localparam int IDX_W     = 8;
    localparam int BPU_DEPTH = 1 << IDX_W;   // 256 entries

    // sequential fetch step
    localparam logic [PC_W-1:0] SEQ_STEP = 32'd4;

    // not-taken path of a branch jumps past its delay slot
    localparam logic [PC_W-1:0] DS_STEP = 32'd8;

    // boot vector, kseg1 rom
    localparam logic [PC_W-1:0] RESET_PC = 32'hbfc00000;

endpackage

// File: common/branch_pkg.sv
package branch_pkg;

    // opcode field width, trace column is read with this
    localparam int BR_OP_W = 3;

    // resolved branch kinds seen by the execute stage
    // compares are on signed register values
    typedef enum logic [BR_OP_W-1:0] {
        BR_BEQ  = 3'd0,  // rs == rt
        BR_BNE  = 3'd1,  // rs != rt
        BR_BLEZ = 3'd2,  // rs <= 0
        BR_BGTZ = 3'd3,  // rs > 0
        BR_BLTZ = 3'd4,  // rs < 0
        BR_BGEZ = 3'd5,  // rs >= 0
        BR_J    = 3'd6   // unconditional
    } br_op_t;

    // 3'd7 is unused and resolves as not taken

endpackage

// File: bpu/bpu.sv
`timescale 1ns/1ps

module bpu (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           bpu_w_en,     // update strobe from resolve
    input  logic [cpu_defs_pkg::PC_W-1:0]  current_pc,   // fetch pc being looked up
    input  logic [cpu_defs_pkg::WPC_W-1:0] tag_pc,       // word addr of resolved branch
    input  logic [cpu_defs_pkg::WPC_W-1:0] next_pc,      // its real next word addr
    output logic [cpu_defs_pkg::PC_W-1:0]  predicted_pc  // next fetch pc guess
);

    // per-entry state bits
    logic [cpu_defs_pkg::BPU_DEPTH-1:0] bpu_valid;    // entry holds a target
    logic [cpu_defs_pkg::BPU_DEPTH-1:0] bpu_predict;  // 1 = tolerate one miss

    // payload arrays
    logic [cpu_defs_pkg::WPC_W-1:0] bpu_tag    [cpu_defs_pkg::BPU_DEPTH];  // full word addr
    logic [cpu_defs_pkg::WPC_W-1:0] bpu_target [cpu_defs_pkg::BPU_DEPTH];

    // lookup side
    logic [cpu_defs_pkg::WPC_W-1:0] cur_word;
    logic [cpu_defs_pkg::IDX_W-1:0] rd_idx;
    logic                           hit;

    // update side
    logic [cpu_defs_pkg::IDX_W-1:0] wr_idx;
    logic                           wr_predict;
    logic                           tag_match;

    assign cur_word = current_pc[cpu_defs_pkg::PC_W-1:cpu_defs_pkg::WORD_LSB];
    assign rd_idx   = cur_word[cpu_defs_pkg::IDX_W-1:0];  // pc[9:2]

    // full tag compare so aliased pcs fall through to pc + 4
    assign hit = bpu_valid[rd_idx] && (bpu_tag[rd_idx] == cur_word);

    always_comb begin
        if (hit) begin
            predicted_pc = {bpu_target[rd_idx], {cpu_defs_pkg::WORD_LSB{1'b0}}};
        end else begin
            predicted_pc = current_pc + cpu_defs_pkg::SEQ_STEP;  // plain sequential fetch
        end
    end

    assign wr_idx     = tag_pc[cpu_defs_pkg::IDX_W-1:0];
    assign wr_predict = bpu_predict[wr_idx];
    assign tag_match  = (bpu_tag[wr_idx] == tag_pc);

    // falling edge so a lookup in the next cycle already sees the update
    always_ff @(negedge clk) begin
        if (rst) begin
            bpu_valid   <= '0;
            bpu_predict <= '0;
        end else if (bpu_w_en) begin
            bpu_valid[wr_idx]   <= 1'b1;         // stays set once written
            bpu_predict[wr_idx] <= ~wr_predict;  // one-bit counter flips on a miss
        end else if (tag_match) begin
            // correct resolve of a known branch pins the bit high
            // only when the slot is actually in use
            bpu_predict[wr_idx] <= bpu_valid[wr_idx];
        end
    end

    // tag and target only replaced while the prediction bit is still 0
    always_ff @(negedge clk) begin
        if (bpu_w_en && !wr_predict) begin
            bpu_tag[wr_idx]    <= tag_pc;
            bpu_target[wr_idx] <= next_pc;
        end
    end

endmodule

// File: verilog/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
    input  logic                            res_valid,    // one resolved branch this cycle
    input  logic [cpu_defs_pkg::PC_W-1:0]   res_pc,       // branch byte addr
    input  branch_pkg::br_op_t              res_op,
    input  logic [cpu_defs_pkg::DATA_W-1:0] rs_val,
    input  logic [cpu_defs_pkg::DATA_W-1:0] rt_val,
    input  logic [cpu_defs_pkg::PC_W-1:0]   res_target,   // taken addr
    input  logic [cpu_defs_pkg::PC_W-1:0]   res_pred_pc,  // what fetch went to after it
    output logic                            mispredict,
    output logic [cpu_defs_pkg::PC_W-1:0]   redirect_pc,  // real next pc
    output logic                            bpu_w_en,
    output logic [cpu_defs_pkg::WPC_W-1:0]  tag_pc,
    output logic [cpu_defs_pkg::WPC_W-1:0]  next_pc
);

    // operands viewed as two's complement
    logic signed [cpu_defs_pkg::DATA_W-1:0] rs_s;
    logic signed [cpu_defs_pkg::DATA_W-1:0] rt_s;

    logic                          taken;
    logic [cpu_defs_pkg::PC_W-1:0] fall_pc;  // not-taken path

    assign rs_s = rs_val;
    assign rt_s = rt_val;

    // condition per opcode, all compares signed
    always_comb begin
        case (res_op)
            branch_pkg::BR_BEQ: begin
                taken = (rs_s == rt_s);
            end
            branch_pkg::BR_BNE: begin
                taken = (rs_s != rt_s);
            end
            branch_pkg::BR_BLEZ: begin
                taken = (rs_s <= 0);
            end
            branch_pkg::BR_BGTZ: begin
                taken = (rs_s > 0);
            end
            branch_pkg::BR_BLTZ: begin
                taken = (rs_s < 0);
            end
            branch_pkg::BR_BGEZ: begin
                taken = (rs_s >= 0);
            end
            branch_pkg::BR_J: begin
                taken = 1'b1;  // jumps always go
            end
            default: begin
                taken = 1'b0;  // spare encoding
            end
        endcase
    end

    // not taken skips the delay slot, so pc + 8
    assign fall_pc     = res_pc + cpu_defs_pkg::DS_STEP;
    assign redirect_pc = taken ? res_target : fall_pc;

    // wrong guess only matters when a branch is really there
    assign mispredict = res_valid && (redirect_pc != res_pred_pc);
    assign bpu_w_en   = mispredict;  // table learns on every miss

    // word addrs for the table, sliced once here
    assign tag_pc  = res_pc[cpu_defs_pkg::PC_W-1:cpu_defs_pkg::WORD_LSB];
    assign next_pc = redirect_pc[cpu_defs_pkg::PC_W-1:cpu_defs_pkg::WORD_LSB];

endmodule

// File: verilog/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mispredict,    // redirect request from resolve
    input  logic [cpu_defs_pkg::PC_W-1:0] redirect_pc,   // corrected next pc
    input  logic [cpu_defs_pkg::PC_W-1:0] predicted_pc,  // from bpu lookup
    output logic [cpu_defs_pkg::PC_W-1:0] fetch_pc
);

    logic [cpu_defs_pkg::PC_W-1:0] pc_next;

    // redirect wins over the prediction
    // stall hold would be added here as a third source
    always_comb begin
        if (mispredict) begin
            pc_next = redirect_pc;
        end else begin
            pc_next = predicted_pc;
        end
    end

    // the only rising-edge state on the fetch side
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= cpu_defs_pkg::RESET_PC;  // boot vector
        end else begin
            fetch_pc <= pc_next;
        end
    end

endmodule

// File: verilog/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            res_valid,
    input  logic [cpu_defs_pkg::PC_W-1:0]   res_pc,
    input  branch_pkg::br_op_t              res_op,
    input  logic [cpu_defs_pkg::DATA_W-1:0] rs_val,
    input  logic [cpu_defs_pkg::DATA_W-1:0] rt_val,
    input  logic [cpu_defs_pkg::PC_W-1:0]   res_target,
    input  logic [cpu_defs_pkg::PC_W-1:0]   res_pred_pc,
    output logic [cpu_defs_pkg::PC_W-1:0]   fetch_pc,
    output logic                            mispredict,
    output logic [cpu_defs_pkg::PC_W-1:0]   redirect_pc
);

    logic [cpu_defs_pkg::PC_W-1:0]  predicted_pc;  // bpu -> pc_gen
    logic                           bpu_w_en;      // resolve -> bpu
    logic [cpu_defs_pkg::WPC_W-1:0] tag_pc;
    logic [cpu_defs_pkg::WPC_W-1:0] next_pc;

    pc_gen u_pc_gen (
        .clk          (clk),
        .rst          (rst),
        .mispredict   (mispredict),
        .redirect_pc  (redirect_pc),
        .predicted_pc (predicted_pc),
        .fetch_pc     (fetch_pc)
    );

    // lookup runs on the current fetch pc
    bpu u_bpu (
        .clk          (clk),
        .rst          (rst),
        .bpu_w_en     (bpu_w_en),
        .current_pc   (fetch_pc),
        .tag_pc       (tag_pc),
        .next_pc      (next_pc),
        .predicted_pc (predicted_pc)
    );

    branch_resolve u_branch_resolve (
        .res_valid    (res_valid),
        .res_pc       (res_pc),
        .res_op       (res_op),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .res_target   (res_target),
        .res_pred_pc  (res_pred_pc),
        .mispredict   (mispredict),
        .redirect_pc  (redirect_pc),
        .bpu_w_en     (bpu_w_en),
        .tag_pc       (tag_pc),
        .next_pc      (next_pc)
    );

endmodule

// File: verif/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int HALF_PERIOD = 10  // ns, gives a 20 ns clock
) (
    output logic clk
);

    initial begin
        clk = 1'b0;  // first rising edge at 10 ns
    end

    always begin
        #(HALF_PERIOD);
        clk = ~clk;
    end

endmodule

// File: verif/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;

    localparam int TRACE_LINES = 39;  // data lines in the trace
    localparam int SKIP_LIMIT  = 8;   // comment or blank lines tolerated in a row
    localparam int RST_CYCLES  = 5;
    localparam int DRIVE_DLY   = 2;   // ns after the rising edge
    localparam int CHECK_DLY   = 15;  // drive point to just before the next edge

    // outcome of one trace read
    localparam int RD_NONE  = 0;
    localparam int RD_DATA  = 1;
    localparam int RD_EOF   = 2;
    localparam int RD_STUCK = 3;
    localparam int RD_BAD   = 4;

    logic                            clk;
    logic                            rst;
    logic                            res_valid;
    logic [cpu_defs_pkg::PC_W-1:0]   res_pc;
    branch_pkg::br_op_t              res_op;
    logic [cpu_defs_pkg::DATA_W-1:0] rs_val;
    logic [cpu_defs_pkg::DATA_W-1:0] rt_val;
    logic [cpu_defs_pkg::PC_W-1:0]   res_target;
    logic [cpu_defs_pkg::PC_W-1:0]   res_pred_pc;
    logic [cpu_defs_pkg::PC_W-1:0]   fetch_pc;
    logic                            mispredict;
    logic [cpu_defs_pkg::PC_W-1:0]   redirect_pc;

    // columns of the current trace line
    logic                             t_valid;
    logic [cpu_defs_pkg::PC_W-1:0]    t_pc;
    logic [branch_pkg::BR_OP_W-1:0]   t_op;
    logic [cpu_defs_pkg::DATA_W-1:0]  t_rs;
    logic [cpu_defs_pkg::DATA_W-1:0]  t_rt;
    logic [cpu_defs_pkg::PC_W-1:0]    t_target;
    logic [cpu_defs_pkg::PC_W-1:0]    t_pred;
    logic                             t_mis;     // expected mispredict
    logic [cpu_defs_pkg::PC_W-1:0]    t_redir;   // expected redirect_pc
    logic [cpu_defs_pkg::PC_W-1:0]    t_fetch;   // expected fetch_pc after the edge

    logic [8*160-1:0] line_buf;
    int               fd;
    int               errors;
    int               checks;
    int               lines_done;
    int               rd_status;

    clk_gen u_clk_gen (
        .clk (clk)
    );

    fetch_top uut (
        .clk         (clk),
        .rst         (rst),
        .res_valid   (res_valid),
        .res_pc      (res_pc),
        .res_op      (res_op),
        .rs_val      (rs_val),
        .rt_val      (rt_val),
        .res_target  (res_target),
        .res_pred_pc (res_pred_pc),
        .fetch_pc    (fetch_pc),
        .mispredict  (mispredict),
        .redirect_pc (redirect_pc)
    );

    // fetch the next data line
    // comment and blank lines scan as zero fields
    task automatic read_trace_line(output int status);
        int n;
        int got;
        int skipped;
        status  = RD_NONE;
        skipped = 0;
        while (status == RD_NONE) begin
            if (skipped >= SKIP_LIMIT) begin
                status = RD_STUCK;  // too many lines without data
            end else begin
                line_buf = '0;
                got = $fgets(line_buf, fd);
                if (got == 0) begin
                    status = RD_EOF;
                end else begin
                    n = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h",
                                t_valid, t_pc, t_op, t_rs, t_rt, t_target, t_pred,
                                t_mis, t_redir, t_fetch);
                    if (n == 10) begin
                        status = RD_DATA;
                    end else if (n <= 0) begin
                        skipped++;
                    end else begin
                        status = RD_BAD;  // partial line
                    end
                end
            end
        end
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        lines_done  = 0;
        rd_status   = RD_DATA;
        rst         = 1'b1;
        res_valid   = 1'b0;
        res_pc      = '0;
        res_op      = branch_pkg::BR_BEQ;
        rs_val      = '0;
        rt_val      = '0;
        res_target  = '0;
        res_pred_pc = '0;

        fd = $fopen("verif/fetch_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file verif/fetch_trace.txt");
            errors++;
        end

        repeat (RST_CYCLES) @(posedge clk);
        #(DRIVE_DLY);
        rst = 1'b0;

        // boot vector straight out of reset
        checks++;
        if (fetch_pc !== cpu_defs_pkg::RESET_PC) begin
            $display("Fail after reset: fetch_pc got %h expected %h",
                     fetch_pc, cpu_defs_pkg::RESET_PC);
            errors++;
        end

        // one trace line per cycle
        while (fd != 0 && lines_done < TRACE_LINES && rd_status == RD_DATA) begin
            read_trace_line(rd_status);
            if (rd_status == RD_DATA) begin
                res_valid   = t_valid;  // 2 ns after the edge
                res_pc      = t_pc;
                res_op      = branch_pkg::br_op_t'(t_op);
                rs_val      = t_rs;
                rt_val      = t_rt;
                res_target  = t_target;
                res_pred_pc = t_pred;

                #(CHECK_DLY);  // resolve outputs settled before the edge
                checks += 2;
                if (mispredict !== t_mis) begin
                    $display("Fail line %0d: mispredict got %h expected %h",
                             lines_done + 1, mispredict, t_mis);
                    errors++;
                end
                if (redirect_pc !== t_redir) begin
                    $display("Fail line %0d: redirect_pc got %h expected %h",
                             lines_done + 1, redirect_pc, t_redir);
                    errors++;
                end

                @(posedge clk);
                #(DRIVE_DLY);
                checks++;
                if (fetch_pc !== t_fetch) begin
                    $display("Fail line %0d: fetch_pc got %h expected %h",
                             lines_done + 1, fetch_pc, t_fetch);
                    errors++;
                end
                lines_done++;
            end
        end

        if (fd != 0) begin
            if (rd_status == RD_EOF) begin
                $display("trace ended early after %0d of %0d lines", lines_done, TRACE_LINES);
                errors++;
            end else if (rd_status == RD_STUCK) begin
                $display("gave up reading the trace, too many lines without data");
                errors++;
            end else if (rd_status == RD_BAD) begin
                $display("malformed trace line after data line %0d", lines_done);
                errors++;
            end
            $fclose(fd);
        end
        res_valid = 1'b0;

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verif/fetch_trace.txt
# valid res_pc op rs_val rt_val res_target res_pred_pc | exp mispredict exp redirect_pc
# exp fetch_pc after the edge, all hex, op is the br_op_t code
0 00000000 0 00000000 00000000 00000000 00000000 0 00000000 bfc00004
0 00000000 0 00000000 00000000 00000000 00000000 0 00000000 bfc00008
0 00000000 0 00000000 00000000 00000000 00000000 0 00000000 bfc0000c
1 00400010 0 00000005 00000005 00400100 00400100 0 00400100 bfc00010
1 00400014 0 00000005 00000006 00400100 00400100 1 0040001c 0040001c
1 00400018 1 00000001 00000002 00400120 00400120 0 00400120 00400020
1 00400024 1 00000007 00000007 00400130 0040002c 0 0040002c 00400024
1 00400028 2 00000000 00000000 00400140 00400030 1 00400140 00400140
1 00400030 2 00000001 00000000 00400150 00400038 0 00400038 00400144
1 00400034 3 00000000 00000000 00400150 0040003c 0 0040003c 00400148
1 00400038 3 7fffffff 00000000 00400160 00400160 0 00400160 0040014c
1 0040003c 4 ffffffff 00000000 00400180 00400044 1 00400180 00400180
1 00400040 4 00000000 00000000 00400190 00400048 0 00400048 00400184
1 00400044 5 00000000 00000000 004001a0 004001a0 0 004001a0 00400188
1 00400048 5 80000000 00000000 004001b0 00400050 0 00400050 0040018c
1 0040004c 6 00000000 00000000 00400200 00400054 1 00400200 00400200
0 00400050 6 00000000 00000000 00400300 00000000 0 00400300 00400204
1 00400300 6 00000000 00000000 00400038 00400308 1 00400038 00400038
0 00000000 0 00000000 00000000 00000000 00000000 0 00000000 0040003c
0 00000000 0 00000000 00000000 00000000 00000000 0 00000000 00400180
0 00000000 0 00000000 00000000 00000000 00000000 0 00000000 00400184
1 0040003c 4 00000001 00000000 00400180 00400180 1 00400044 00400044
0 00000000 0 00000000 00000000 00000000 00000000 0 00000000 00400048
1 00400304 6 00000000 00000000 0040003c 0040030c 1 0040003c 0040003c
0 00000000 0 00000000 00000000 00000000 00000000 0 00000000 00400180
1 0040003c 4 ffffffff 00000000 00400180 00400180 0 00400180 00400184
1 0040003c 4 00000005 00000000 00400180 00400180 1 00400044 00400044
1 00400308 6 00000000 00000000 00400038 00400310 1 00400038 00400038
0 00000000 0 00000000 00000000 00000000 00000000 0 00000000 0040003c
0 00000000 0 00000000 00000000 00000000 00000000 0 00000000 00400180
1 0040030c 6 00000000 00000000 0040043c 00400314 1 0040043c 0040043c
0 00000000 0 00000000 00000000 00000000 00000000 0 00000000 00400440
0 00000000 0 00000000 00000000 00000000 00000000 0 00000000 00400444
1 00400500 0 00000003 00000003 00400600 00400508 1 00400600 00400600
1 00400504 1 00000003 00000003 00400610 00400600 1 0040050c 0040050c
1 00400508 3 00000002 00000000 00400700 00400510 1 00400700 00400700
1 0040050c 2 fffffffe 00000000 00400800 00400514 1 00400800 00400800
0 00000000 0 00000000 00000000 00000000 00000000 0 00000000 00400804
0 00000000 0 00000000 00000000 00000000 00000000 0 00000000 00400808

// File: verilog.f
common/cpu_defs_pkg.sv
common/branch_pkg.sv
bpu/bpu.sv
verilog/branch_resolve.sv
verilog/pc_gen.sv
verilog/fetch_top.sv
verif/clk_gen.sv
verif/tb_fetch.sv
